// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= kv_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
source/kv_defines_pkg.sv
source/kv_axil_pkg.sv
source/kv_axil_regs.sv
source/kv_store.sv
source/kv_fsm.sv
source/kv_block_sink.sv
source/kv_top.sv
tb/kv_clk_gen.sv
tb/kv_tb.sv

// ==== source/kv_axil_pkg.sv ====
// 12-bit AXI4-Lite register map with 32-bit data; only OKAY and SLVERR responses are ever returned
package kv_axil_pkg;

    localparam int KV_AXIL_ADDR_W = 12;

    localparam logic [1:0] KV_RESP_OKAY = 2'b00;
    localparam logic [1:0] KV_RESP_SLVERR = 2'b10;

    // go in bit 0, entry in bits 2:1, pad_data_size in bits 12:8
    localparam logic [KV_AXIL_ADDR_W-1:0] KV_ADDR_CTRL = 12'h000;
    // ready in bit 0, sticky done in bit 1
    localparam logic [KV_AXIL_ADDR_W-1:0] KV_ADDR_STATUS = 12'h004;
    // one set-only lock bit per entry
    localparam logic [KV_AXIL_ADDR_W-1:0] KV_ADDR_LOCK = 12'h008;
    // write-only key window, entry e dword d at base + 64*e + 4*d
    localparam logic [KV_AXIL_ADDR_W-1:0] KV_ADDR_KEY_BASE = 12'h100;
    // read-only window onto the 32 destination block dwords
    localparam logic [KV_AXIL_ADDR_W-1:0] KV_ADDR_BLOCK_BASE = 12'h200;

endpackage

// ==== source/kv_axil_regs.sv ====
// one write and one read outstanding; wstrb is only tested for all-zero, so any partial write acts as a full word
`timescale 1ns/10ps

module kv_axil_regs #(
    parameter int DATA_WIDTH = 512
) (
    input  logic clk,
    input  logic rst_b,
    input  logic [kv_axil_pkg::KV_AXIL_ADDR_W-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [kv_axil_pkg::KV_AXIL_ADDR_W-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    input  logic ready,
    input  logic done,
    output logic start,
    output logic [kv_defines_pkg::KV_PAD_SIZE_W-1:0] pad_data_size,
    output logic [kv_defines_pkg::KV_ENTRY_W-1:0] xfer_entry,
    output logic key_we,
    output logic [kv_defines_pkg::KV_ENTRY_W-1:0] key_entry,
    output logic [$clog2(kv_defines_pkg::KV_ENTRY_DWORDS)-1:0] key_dword,
    output logic [31:0] key_wdata,
    input  logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] lock,
    output logic lock_we,
    output logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] lock_wdata,
    output logic [kv_defines_pkg::KV_NUM_DWORDS_W-1:0] blk_rd_index,
    input  logic [31:0] blk_rd_data
);
    import kv_defines_pkg::*;
    import kv_axil_pkg::*;

    localparam int AW = KV_AXIL_ADDR_W;
    // largest N the sequencer can fetch, one extra bit so 16 fits
    localparam logic [KV_PAD_SIZE_W:0] SIZE_LIMIT = (KV_PAD_SIZE_W + 1)'(DATA_WIDTH / 32);

    logic wr_acc, wr_do, wr_err;
    logic wr_ctrl, wr_status, wr_lock, wr_key, wr_block;
    logic go_ok, size_ok;
    logic rd_acc, rd_err;
    logic [31:0] rd_word;
    logic done_q;

    // AW and W are taken together, and only when no B response is still waiting
    assign wr_acc = awvalid & wvalid & ~bvalid;
    assign awready = wr_acc;
    assign wready = wr_acc;

    // registers compare word addresses, the windows compare only their upper bits
    assign wr_ctrl = awaddr[AW-1:2] == KV_ADDR_CTRL[AW-1:2];
    assign wr_status = awaddr[AW-1:2] == KV_ADDR_STATUS[AW-1:2];
    assign wr_lock = awaddr[AW-1:2] == KV_ADDR_LOCK[AW-1:2];
    assign wr_key = awaddr[AW-1:8] == KV_ADDR_KEY_BASE[AW-1:8];
    assign wr_block = awaddr[AW-1:7] == KV_ADDR_BLOCK_BASE[AW-1:7];

    // a go is only taken when idle and when N dwords fit in what the sequencer fetches
    assign size_ok = ({1'b0, wdata[12:8]} + 1'b1) <= SIZE_LIMIT;
    assign go_ok = wr_ctrl & wdata[0] & ready & size_ok;

    // refused go, locked key, block window and unmapped addresses all answer SLVERR
    assign wr_err = (wr_ctrl & wdata[0] & ~go_ok) | (wr_key & lock[key_entry]) | wr_block |
                    ~(wr_ctrl | wr_status | wr_lock | wr_key | wr_block);

    // a write with no strobes set still gets a response but changes nothing
    assign wr_do = wr_acc & ~wr_err & (|wstrb);

    assign key_entry = awaddr[7:6];
    assign key_dword = awaddr[5:2];
    assign key_wdata = wdata;
    assign key_we = wr_do & wr_key;
    assign lock_wdata = wdata[KV_NUM_ENTRIES-1:0];
    assign lock_we = wr_do & wr_lock;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            bvalid <= 1'b0;
            start <= 1'b0;
            done_q <= 1'b0;
            xfer_entry <= '0;
            pad_data_size <= '0;
        end else begin
            // start is a single pulse in the cycle after the accepted go
            start <= wr_do & go_ok;
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // entry and size only move on an accepted go, so they stay put until done
            if (wr_do && go_ok) begin
                xfer_entry <= wdata[2:1];
                pad_data_size <= wdata[12:8];
                done_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bresp <= wr_err ? KV_RESP_SLVERR : KV_RESP_OKAY;
        end
    end

    // AR is taken only when the previous R beat has gone
    assign rd_acc = arvalid & ~rvalid;
    assign arready = rd_acc;
    assign blk_rd_index = araddr[6:2];

    always_comb begin
        rd_word = '0;
        rd_err = 1'b0;
        if (araddr[AW-1:2] == KV_ADDR_CTRL[AW-1:2]) begin
            rd_word[2:1] = xfer_entry;
            rd_word[12:8] = pad_data_size;
        end else if (araddr[AW-1:2] == KV_ADDR_STATUS[AW-1:2]) begin
            rd_word[1:0] = {done_q, ready};
        end else if (araddr[AW-1:2] == KV_ADDR_LOCK[AW-1:2]) begin
            rd_word[KV_NUM_ENTRIES-1:0] = lock;
        end else if (araddr[AW-1:7] == KV_ADDR_BLOCK_BASE[AW-1:7]) begin
            rd_word = blk_rd_data;
        end else begin
            // key window is write-only, so it falls in with the unmapped space
            rd_err = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rvalid <= 1'b0;
        end else if (rd_acc) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata <= rd_word;
            rresp <= rd_err ? KV_RESP_SLVERR : KV_RESP_OKAY;
        end
    end

endmodule

// ==== source/kv_block_sink.sv ====
// single 1024-bit destination block; a new transfer overwrites it dword by dword with no clear in between
`timescale 1ns/10ps

module kv_block_sink (
    input  logic clk,
    input  logic rst_b,
    input  logic write_en,
    input  logic [kv_defines_pkg::KV_NUM_DWORDS_W-1:0] write_offset,
    input  logic write_pad,
    input  logic [31:0] pad_data,
    input  logic [31:0] rd_data,
    input  logic [kv_defines_pkg::KV_NUM_DWORDS_W-1:0] blk_rd_index,
    output logic [31:0] blk_rd_data
);
    import kv_defines_pkg::*;

    logic [KV_MAX_DWORDS-1:0][31:0] block_q;

    // the block starts out zero so an early readback never shows stale data
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            block_q <= '0;
        end else if (write_en) begin
            // pad dwords come from the sequencer, data dwords straight from the store
            block_q[write_offset] <= write_pad ? pad_data : rd_data;
        end
    end

    // the bus slave registers this on its own R channel
    assign blk_rd_data = block_q[blk_rd_index];

endmodule

// ==== source/kv_defines_pkg.sv ====
// vault geometry is fixed at four 512-bit entries feeding one 1024-bit block, so widths below must change together
package kv_defines_pkg;

    // number of key entries and the width of an entry index
    localparam int KV_NUM_ENTRIES = 4;
    localparam int KV_ENTRY_W = 2;

    // each entry holds 512 bits of key material as 16 dwords
    localparam int KV_ENTRY_DWORDS = 16;

    // the destination block is one 1024-bit SHA-512 block
    localparam int KV_MAX_DWORDS = 32;
    localparam int KV_NUM_DWORDS_W = 5;

    // dwords 28 to 31 are where SHA-512 keeps its 128-bit length field
    localparam int KV_PAD_LENGTH_START = 28;

    // pad_data_size holds the data length as N-1 dwords
    localparam int KV_PAD_SIZE_W = 5;

endpackage

// ==== source/kv_fsm.sv ====
// N may not exceed the 16 dwords of an entry, and the length dword is only written when pad_data_size is below 27
`timescale 1ns/10ps

module kv_fsm #(
    parameter int DATA_WIDTH = 512,
    parameter int PAD = 1,
    parameter int HMAC = 0
) (
    input  logic clk,
    input  logic rst_b,
    input  logic start,
    input  logic [kv_defines_pkg::KV_PAD_SIZE_W-1:0] pad_data_size,
    output logic [$clog2(kv_defines_pkg::KV_ENTRY_DWORDS)-1:0] read_offset,
    output logic write_en,
    output logic [kv_defines_pkg::KV_NUM_DWORDS_W-1:0] write_offset,
    output logic write_pad,
    output logic [31:0] pad_data,
    output logic ready,
    output logic done
);
    import kv_defines_pkg::*;

    // one bit wider than a dword index so the count can reach 32
    typedef logic [KV_NUM_DWORDS_W:0] count_t;

    localparam int OFFSET_W = $clog2(KV_ENTRY_DWORDS);
    localparam count_t DATA_DWORDS = count_t'(DATA_WIDTH / 32);
    // HMAC hashes the 1024-bit key block ahead of this one, so its length counts too
    localparam logic [31:0] HMAC_BITS = (HMAC == 1) ? 32'd1024 : 32'd0;

    typedef enum logic [1:0] {
        KV_IDLE = 2'b00,
        KV_RW   = 2'b01,
        KV_PAD  = 2'b11,
        KV_DONE = 2'b10
    } kv_state_e;

    kv_state_e state, state_nxt;
    count_t offset, offset_nxt;
    count_t num_dwords_data, num_dwords_total;
    logic offset_en;
    logic has_length;
    logic [31:0] pad_length;

    // with padding the data length comes from software as N-1, otherwise it is the full width
    assign num_dwords_data = (PAD == 1) ? count_t'(pad_data_size) + 1'b1 : DATA_DWORDS;
    assign num_dwords_total = (PAD == 1) ? count_t'(KV_MAX_DWORDS) : DATA_DWORDS;

    // marker plus length must both fit before the length field, else the length goes in a later block
    assign has_length = pad_data_size < KV_PAD_SIZE_W'(KV_PAD_LENGTH_START - 1);
    assign pad_length = (32'(num_dwords_data) << 5) + HMAC_BITS;

    always_comb begin
        pad_data = '0;
        if (offset == num_dwords_data) begin
            pad_data = 32'h8000_0000;
        end else if (offset == count_t'(KV_MAX_DWORDS - 1) && has_length) begin
            pad_data = pad_length;
        end
    end

    always_comb begin
        state_nxt = state;
        write_en = 1'b0;
        write_pad = 1'b0;
        done = 1'b0;
        offset_en = 1'b0;
        offset_nxt = '0;
        case (state)
            KV_IDLE: begin
                if (start) begin
                    state_nxt = KV_RW;
                end
            end
            KV_RW: begin
                write_en = 1'b1;
                offset_en = 1'b1;
                offset_nxt = offset + 1'b1;
                // a full-width transfer has no room left to pad
                if (offset_nxt == num_dwords_total) begin
                    state_nxt = KV_DONE;
                end else if (PAD == 1 && offset_nxt == num_dwords_data) begin
                    state_nxt = KV_PAD;
                end
            end
            KV_PAD: begin
                write_en = 1'b1;
                write_pad = 1'b1;
                offset_en = 1'b1;
                offset_nxt = offset + 1'b1;
                if (offset_nxt == num_dwords_total) begin
                    state_nxt = KV_DONE;
                end
            end
            default: begin
                // done lasts one cycle and rewinds the shared offset
                done = 1'b1;
                offset_en = 1'b1;
                state_nxt = KV_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= KV_IDLE;
            offset <= '0;
        end else begin
            state <= state_nxt;
            if (offset_en) begin
                offset <= offset_nxt;
            end
        end
    end

    // one counter serves both sides, the store only sees the low bits during data
    assign read_offset = offset[OFFSET_W-1:0];
    assign write_offset = offset[KV_NUM_DWORDS_W-1:0];
    assign ready = state == KV_IDLE;

endmodule

// ==== source/kv_store.sv ====
// keys are not reset and are never readable from the bus; lock bits are set-only and clear only on reset
`timescale 1ns/10ps

module kv_store (
    input  logic clk,
    input  logic rst_b,
    input  logic key_we,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0] key_entry,
    input  logic [$clog2(kv_defines_pkg::KV_ENTRY_DWORDS)-1:0] key_dword,
    input  logic [31:0] key_wdata,
    input  logic lock_we,
    input  logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] lock_wdata,
    output logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] lock,
    input  logic [kv_defines_pkg::KV_ENTRY_W-1:0] xfer_entry,
    input  logic [$clog2(kv_defines_pkg::KV_ENTRY_DWORDS)-1:0] read_offset,
    output logic [31:0] rd_data
);
    import kv_defines_pkg::*;

    logic [31:0] key_mem [KV_NUM_ENTRIES][KV_ENTRY_DWORDS];

    // the bus slave has already refused locked entries before raising key_we
    always_ff @(posedge clk) begin
        if (key_we) begin
            key_mem[key_entry][key_dword] <= key_wdata;
        end
    end

    // writing a one locks an entry, writing a zero leaves its bit alone
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock <= '0;
        end else if (lock_we) begin
            lock <= lock | lock_wdata;
        end
    end

    // asynchronous read so the dword lines up with write_en in the same cycle
    assign rd_data = key_mem[xfer_entry][read_offset];

endmodule

// ==== source/kv_top.sv ====
// DATA_WIDTH must be a multiple of 32 up to 512; with PAD set the go size check limits N to DATA_WIDTH/32
`timescale 1ns/10ps

module kv_top #(
    parameter int DATA_WIDTH = 512,
    parameter int PAD = 1,
    parameter int HMAC = 0
) (
    input  logic clk,
    input  logic rst_b,
    input  logic [kv_axil_pkg::KV_AXIL_ADDR_W-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [31:0] wdata,
    input  logic [3:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [kv_axil_pkg::KV_AXIL_ADDR_W-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready
);
    import kv_defines_pkg::*;

    // sequencer control and status
    logic start, ready, done;
    logic [KV_PAD_SIZE_W-1:0] pad_data_size;
    logic [KV_ENTRY_W-1:0] xfer_entry;

    // bus writes into the key store
    logic key_we, lock_we;
    logic [KV_ENTRY_W-1:0] key_entry;
    logic [$clog2(KV_ENTRY_DWORDS)-1:0] key_dword;
    logic [31:0] key_wdata;
    logic [KV_NUM_ENTRIES-1:0] lock, lock_wdata;

    // data path from store through sequencer into the block
    logic [$clog2(KV_ENTRY_DWORDS)-1:0] read_offset;
    logic [31:0] rd_data, pad_data, blk_rd_data;
    logic write_en, write_pad;
    logic [KV_NUM_DWORDS_W-1:0] write_offset, blk_rd_index;

    // every port name matches its wire, so implicit connections keep the wiring readable
    kv_axil_regs #(.DATA_WIDTH(DATA_WIDTH)) kv_axil_regs_i (.*);

    kv_store kv_store_i (.*);

    kv_fsm #(
        .DATA_WIDTH(DATA_WIDTH),
        .PAD(PAD),
        .HMAC(HMAC)
    ) kv_fsm_i (.*);

    kv_block_sink kv_block_sink_i (.*);

endmodule

// ==== tb/kv_clk_gen.sv ====
// free-running clock from time zero; reset is released 1 ns after its last held rising edge
`timescale 1ns/10ps

module kv_clk_gen #(
    parameter int PERIOD = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_b
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset stays low for a fixed number of rising edges
    initial begin
        rst_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_b = 1'b1;
    end

endmodule

// ==== tb/kv_tb.sv ====
// checks kv_top with its default parameters (DATA_WIDTH 512, PAD 1, HMAC 0) only; the first mismatch ends the run
`timescale 1ns/10ps

module kv_tb;
    import kv_defines_pkg::*;
    import kv_axil_pkg::*;

    localparam int WAIT_LIMIT = 64;
    localparam int POLL_LIMIT = 40;
    // x^32 + x^22 + x^2 + x + 1 in Galois form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // the DUT runs with HMAC off, so no key block ahead of this one counts toward the length
    localparam int HMAC_BITS = 0;

    logic clk, rst_b;
    logic [KV_AXIL_ADDR_W-1:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    logic [31:0] lfsr;
    logic [31:0] key_model [KV_NUM_ENTRIES][KV_ENTRY_DWORDS];

    kv_clk_gen #(.PERIOD(10), .RESET_CYCLES(8)) kv_clk_gen_i (.clk(clk), .rst_b(rst_b));

    kv_top kv_top_i (.*);

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        $display("Done: errors found");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_stuck(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "%s", what);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit, msb first
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [KV_AXIL_ADDR_W-1:0] key_addr(input int e, input int d);
        return KV_ADDR_KEY_BASE + KV_AXIL_ADDR_W'(64 * e + 4 * d);
    endfunction

    function automatic logic [31:0] ctrl_word(input int entry, input int size);
        return (32'(size) << 8) | (32'(entry) << 1) | 32'd1;
    endfunction

    // SHA-512 padding: N key dwords, a marker, zeroes, then the bit length in dword 31
    function automatic logic [31:0] expected_dword(input int entry, input int size, input int idx);
        int n;
        n = size + 1;
        if (idx < n) begin
            return key_model[entry][idx];
        end
        if (idx == n) begin
            return 32'h8000_0000;
        end
        if (idx == KV_MAX_DWORDS - 1 && size < 27) begin
            return 32'(n * 32 + HMAC_BITS);
        end
        return 32'h0;
    endfunction

    // sel picks the condition: 0 AW and W ready, 1 bvalid, 2 arready, 3 rvalid
    task automatic wait_high(input int sel, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!((sel == 0 && awready && wready) || (sel == 1 && bvalid) ||
                 (sel == 2 && arready) || (sel == 3 && rvalid))) begin
            t++;
            if (t > WAIT_LIMIT) begin
                report_stuck(what);
            end
            @(negedge clk);
        end
    endtask

    task automatic axil_write(input logic [KV_AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        @(posedge clk);
        #1;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        wait_high(0, "write address and data were never accepted");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        wait_high(1, "no write response arrived");
        resp = bresp;
        // bready is held low, so the response has to sit still
        repeat (stall) begin
            @(negedge clk);
            assert (bvalid) else report_mismatch("bvalid", 32'd1, 32'(bvalid));
            assert (bresp == resp) else report_mismatch("bresp", 32'(resp), 32'(bresp));
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [KV_AXIL_ADDR_W-1:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        #1;
        araddr = addr;
        arvalid = 1'b1;
        wait_high(2, "read address was never accepted");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        wait_high(3, "no read data arrived");
        data = rdata;
        resp = rresp;
        repeat (stall) begin
            @(negedge clk);
            assert (rvalid) else report_mismatch("rvalid", 32'd1, 32'(rvalid));
            assert (rresp == resp) else report_mismatch("rresp", 32'(resp), 32'(rresp));
            assert (rdata == data) else report_mismatch("rdata", data, rdata);
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // every access holds its response back for 0 to 3 cycles
    task automatic write_check(input logic [KV_AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic [1:0] exp_resp);
        logic [31:0] stall;
        logic [1:0] resp;
        take_bits(2, stall);
        axil_write(addr, data, int'(stall), resp);
        assert (resp == exp_resp) else report_mismatch("bresp", 32'(exp_resp), 32'(resp));
    endtask

    task automatic read_check(input logic [KV_AXIL_ADDR_W-1:0] addr, input logic [1:0] exp_resp,
                              output logic [31:0] data);
        logic [31:0] stall;
        logic [1:0] resp;
        take_bits(2, stall);
        axil_read(addr, int'(stall), data, resp);
        assert (resp == exp_resp) else report_mismatch("rresp", 32'(exp_resp), 32'(resp));
    endtask

    task automatic check_block(input int entry, input int size);
        logic [31:0] got;
        for (int i = 0; i < KV_MAX_DWORDS; i++) begin
            read_check(KV_ADDR_BLOCK_BASE + KV_AXIL_ADDR_W'(4 * i), KV_RESP_OKAY, got);
            assert (got == expected_dword(entry, size, i))
                else report_mismatch($sformatf("block[%0d]", i), expected_dword(entry, size, i), got);
        end
    endtask

    task automatic run_transfer(input int entry, input int size, input bit probe_busy);
        logic [31:0] st;
        int polls;
        write_check(KV_ADDR_CTRL, ctrl_word(entry, size), KV_RESP_OKAY);
        if (probe_busy) begin
            // the sequencer is still walking the entry, so this go is refused
            write_check(KV_ADDR_CTRL, ctrl_word(entry, size), KV_RESP_SLVERR);
        end
        polls = 0;
        read_check(KV_ADDR_STATUS, KV_RESP_OKAY, st);
        while (!st[1]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_stuck("transfer never reported done");
            end
            read_check(KV_ADDR_STATUS, KV_RESP_OKAY, st);
        end
        assert (st[0]) else report_mismatch("status.ready", 32'd1, 32'(st[0]));
        check_block(entry, size);
    endtask

    initial begin
        logic [31:0] val, ctrl_before;
        int entry, size, locked, other, t;
        awaddr = '0;
        wdata = '0;
        wstrb = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        lfsr = 32'd60;
        t = 0;
        while (rst_b !== 1'b1) begin
            t++;
            if (t > WAIT_LIMIT) begin
                report_stuck("reset was never released");
            end
            @(posedge clk);
        end

        // after reset the sequencer is idle and the block is clear
        read_check(KV_ADDR_STATUS, KV_RESP_OKAY, val);
        assert (val == 32'h1) else report_mismatch("status", 32'h1, val);
        for (int i = 0; i < KV_MAX_DWORDS; i++) begin
            read_check(KV_ADDR_BLOCK_BASE + KV_AXIL_ADDR_W'(4 * i), KV_RESP_OKAY, val);
            assert (val == 32'h0) else report_mismatch($sformatf("block[%0d]", i), 32'h0, val);
        end

        for (int e = 0; e < KV_NUM_ENTRIES; e++) begin
            for (int d = 0; d < KV_ENTRY_DWORDS; d++) begin
                take_bits(32, val);
                key_model[e][d] = val;
                write_check(key_addr(e, d), val, KV_RESP_OKAY);
            end
        end

        // two random transfers, the second overwrites the first block
        for (int k = 0; k < 2; k++) begin
            take_bits(2, val);
            entry = int'(val[1:0]);
            take_bits(4, val);
            size = int'(val[3:0]);
            run_transfer(entry, size, k == 0);
        end

        // a locked entry keeps its old key while its neighbour still takes writes
        take_bits(2, val);
        locked = int'(val[1:0]);
        other = (locked + 1) % KV_NUM_ENTRIES;
        write_check(KV_ADDR_LOCK, 32'(1) << locked, KV_RESP_OKAY);
        take_bits(32, val);
        write_check(key_addr(locked, 0), val, KV_RESP_SLVERR);
        write_check(key_addr(other, 0), val, KV_RESP_OKAY);
        key_model[other][0] = val;
        run_transfer(locked, 15, 1'b0);
        run_transfer(other, 15, 1'b0);

        // refused accesses leave control, status, lock and block untouched
        read_check(KV_ADDR_CTRL, KV_RESP_OKAY, ctrl_before);
        take_bits(4, val);
        write_check(KV_ADDR_CTRL, ctrl_word(0, 16 + int'(val[3:0])), KV_RESP_SLVERR);
        read_check(key_addr(other, 0), KV_RESP_SLVERR, val);
        write_check(KV_ADDR_BLOCK_BASE, 32'hdead_beef, KV_RESP_SLVERR);
        write_check(12'h00c, 32'hffff_ffff, KV_RESP_SLVERR);
        read_check(12'h00c, KV_RESP_SLVERR, val);
        read_check(KV_ADDR_CTRL, KV_RESP_OKAY, val);
        assert (val == ctrl_before) else report_mismatch("ctrl", ctrl_before, val);
        read_check(KV_ADDR_STATUS, KV_RESP_OKAY, val);
        assert (val == 32'h3) else report_mismatch("status", 32'h3, val);
        read_check(KV_ADDR_LOCK, KV_RESP_OKAY, val);
        assert (val == 32'(1) << locked) else report_mismatch("lock", 32'(1) << locked, val);
        check_block(other, 15);

        $display("Done: no errors");
        $finish;
    end

endmodule
